// File: source/rp_pkg.sv
/* analog core package
   shared sizes, sample and bus types, pin code conversion */
`default_nettype none

package rp_pkg;

  ////////////////////
  // sizes
  ////////////////////

  localparam int SMP_W      = 14;                 // adc/dac sample width
  localparam int MUL_W      = 16;                 // gain width
  localparam int GAIN_SHIFT = 14;                 // product shift, 2^14 is unity
  localparam logic signed [MUL_W-1:0] GAIN_ONE = 16'sd16384;

  localparam int BUS_W      = 32;                 // bus addr and data
  localparam int N_REGIONS  = 8;
  localparam int REGION_LSB = 20;                 // region field is addr[22:20]
  localparam int REGION_W   = $clog2(N_REGIONS);
  localparam int REGION_HK    = 0;
  localparam int REGION_CALIB = 1;

  localparam int LED_W      = 8;

  ////////////////////
  // types
  ////////////////////

  typedef logic signed [SMP_W-1:0] sample_t;
  typedef logic signed [MUL_W-1:0] gain_t;

  typedef struct packed {
    sample_t ch0;
    sample_t ch1;
  } sample_pair_t;                                // two's complement pair

  typedef struct packed {
    logic [SMP_W-1:0] ch0;
    logic [SMP_W-1:0] ch1;
  } pin_pair_t;                                   // negative slope offset binary

  typedef struct packed {
    gain_t   gain;
    sample_t offset;
  } lin_cfg_t;

  typedef struct packed {
    lin_cfg_t [1:0] adc_cfg;                      // index is channel
    lin_cfg_t [1:0] dac_cfg;
  } calib_cfg_t;

  typedef struct packed {
    logic [BUS_W-1:0] addr;
    logic [BUS_W-1:0] wdata;
    logic             wen;                        // single cycle pulse
    logic             ren;                        // single cycle pulse
  } sys_req_t;

  typedef struct packed {
    logic [BUS_W-1:0] rdata;
    logic             ack;
  } sys_rsp_t;

  // same flip in both directions, msb kept and the rest inverted
  function automatic logic [SMP_W-1:0] neg_slope(input logic [SMP_W-1:0] d);
    return {d[SMP_W-1], ~d[SMP_W-2:0]};
  endfunction

endpackage

`default_nettype wire

// File: source/sys_bus_decoder.sv
/* system bus decoder
   splits the address space into eight regions, gates strobes per block,
   muxes responses back and answers unmapped regions in the same cycle */
`timescale 1ns/1ps
`default_nettype none

module sys_bus_decoder import rp_pkg::*; (
  input  sys_req_t sys_req_i,  // from bus master
  output sys_rsp_t sys_rsp_o,
  // housekeeping block
  output sys_req_t hk_req_o,
  input  sys_rsp_t hk_rsp_i,
  // calibration block
  output sys_req_t cal_req_o,
  input  sys_rsp_t cal_rsp_i
);

////////////////////
// region decode
////////////////////

logic [REGION_W-1:0] region;
logic                hk_sel;
logic                cal_sel;

assign region  = sys_req_i.addr[REGION_LSB +: REGION_W];
assign hk_sel  = (region == REGION_W'(REGION_HK));
assign cal_sel = (region == REGION_W'(REGION_CALIB));

// addr and wdata fan out unchanged, strobes only to the selected block
always_comb
begin
  hk_req_o      = sys_req_i;
  hk_req_o.wen  = sys_req_i.wen & hk_sel;
  hk_req_o.ren  = sys_req_i.ren & hk_sel;
  cal_req_o     = sys_req_i;
  cal_req_o.wen = sys_req_i.wen & cal_sel;
  cal_req_o.ren = sys_req_i.ren & cal_sel;
end

////////////////////
// response mux
////////////////////

always_comb
begin
  sys_rsp_o = '0;
  if (hk_sel)
    sys_rsp_o = hk_rsp_i;
  else if (cal_sel)
    sys_rsp_o = cal_rsp_i;
  else
    sys_rsp_o.ack = sys_req_i.wen | sys_req_i.ren;  // unmapped, zero data, no wait
end

endmodule

`default_nettype wire

// File: source/housekeeping_regs.sv
/* housekeeping registers
   leds, digital loop switch and static dac levels on bus region 0 */
`timescale 1ns/1ps
`default_nettype none

module housekeeping_regs import rp_pkg::*; (
  input  logic             adc_clk,
  input  logic             top_rst,
  // bus
  input  sys_req_t         req_i,
  output sys_rsp_t         rsp_o,
  // control outputs
  output logic [LED_W-1:0] led_o,
  output logic             digital_loop_o,
  output sample_pair_t     dac_level_o     // static dac source
);

logic [REGION_LSB-1:0] ofs;     // byte offset inside the region
logic [BUS_W-1:0]      rd_val;
logic [BUS_W-1:0]      rdata_q;
logic                  ack_q;

assign ofs = req_i.addr[REGION_LSB-1:0];

////////////////////
// register writes
////////////////////

always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
  begin
    digital_loop_o <= 1'b0;
    led_o          <= '0;
    dac_level_o    <= '0;
  end
  else if (req_i.wen)
  begin
    case (ofs)
      'h0: digital_loop_o  <= req_i.wdata[0];
      'h4: led_o           <= req_i.wdata[LED_W-1:0];
      'h8: dac_level_o.ch0 <= req_i.wdata[SMP_W-1:0];
      'hC: dac_level_o.ch1 <= req_i.wdata[SMP_W-1:0];
      default: ;                                     // hole, write dropped
    endcase
  end
end

////////////////////
// readback
////////////////////

always_comb
begin
  rd_val = '0;                                       // holes read zero
  case (ofs)
    'h0: rd_val[0]            = digital_loop_o;
    'h4: rd_val[LED_W-1:0]    = led_o;
    'h8: rd_val[SMP_W-1:0]    = dac_level_o.ch0;
    'hC: rd_val[SMP_W-1:0]    = dac_level_o.ch1;
    default: rd_val = '0;
  endcase
end

always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
    ack_q <= 1'b0;
  else
    ack_q <= req_i.wen | req_i.ren;                  // one cycle after strobe
end

always_ff @(posedge adc_clk)
begin
  if (req_i.ren)
    rdata_q <= rd_val;
end

assign rsp_o = '{rdata: rdata_q, ack: ack_q};

endmodule

`default_nettype wire

// File: source/calib_regs.sv
/* calibration registers
   adc and dac gain/offset per channel on bus region 1, unity gain at reset */
`timescale 1ns/1ps
`default_nettype none

module calib_regs import rp_pkg::*; (
  input  logic       adc_clk,
  input  logic       top_rst,
  // bus
  input  sys_req_t   req_i,
  output sys_rsp_t   rsp_o,
  // calibration to datapaths
  output calib_cfg_t calib_o
);

logic [REGION_LSB-1:0] ofs;
logic                  hit;      // offset lands on one of the eight registers
lin_cfg_t              rd_cfg;
logic [BUS_W-1:0]      rd_val;
logic [BUS_W-1:0]      rdata_q;
logic                  ack_q;

// ofs[4] dac, ofs[3] offset, ofs[2] channel
assign ofs = req_i.addr[REGION_LSB-1:0];
assign hit = (ofs[REGION_LSB-1:5] == '0) && (ofs[1:0] == 2'b00);

////////////////////
// register writes
////////////////////

always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
  begin
    for (int i = 0; i < 2; i++)
    begin
      calib_o.adc_cfg[i] <= '{gain: GAIN_ONE, offset: '0};
      calib_o.dac_cfg[i] <= '{gain: GAIN_ONE, offset: '0};
    end
  end
  else if (req_i.wen && hit)
  begin
    case (ofs[4:3])
      2'b00:   calib_o.adc_cfg[ofs[2]].gain   <= req_i.wdata[MUL_W-1:0];
      2'b01:   calib_o.adc_cfg[ofs[2]].offset <= req_i.wdata[SMP_W-1:0];
      2'b10:   calib_o.dac_cfg[ofs[2]].gain   <= req_i.wdata[MUL_W-1:0];
      default: calib_o.dac_cfg[ofs[2]].offset <= req_i.wdata[SMP_W-1:0];
    endcase
  end
end

////////////////////
// readback
////////////////////

assign rd_cfg = ofs[4] ? calib_o.dac_cfg[ofs[2]] : calib_o.adc_cfg[ofs[2]];

// fields come back zero extended, not sign extended
assign rd_val = !hit   ? '0 :
                ofs[3] ? {{(BUS_W-SMP_W){1'b0}}, rd_cfg.offset} :
                         {{(BUS_W-MUL_W){1'b0}}, rd_cfg.gain};

always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
    ack_q <= 1'b0;
  else
    ack_q <= req_i.wen | req_i.ren;
end

always_ff @(posedge adc_clk)
begin
  if (req_i.ren)
    rdata_q <= rd_val;
end

assign rsp_o = '{rdata: rdata_q, ack: ack_q};

endmodule

`default_nettype wire

// File: source/linear_scaler.sv
/* linear scaler
   registered gain, shift, offset and saturation for one channel */
`timescale 1ns/1ps
`default_nettype none

module linear_scaler import rp_pkg::*; (
  input  logic     adc_clk,
  input  logic     top_rst,
  input  sample_t  dat_i,
  input  lin_cfg_t cfg_i,
  output sample_t  dat_o
);

////////////////////
// arithmetic
////////////////////

// full product, 14x16 signed
logic signed [SMP_W+MUL_W-1:0]            prod;
// after dropping the GAIN_SHIFT fraction bits
logic signed [SMP_W+MUL_W-GAIN_SHIFT-1:0] prod_shr;
// one guard bit for the offset add
logic signed [SMP_W+MUL_W-GAIN_SHIFT:0]   sum;
logic                                     sum_ok;   // fits in SMP_W
sample_t                                  sat;

assign prod     = dat_i * cfg_i.gain;
assign prod_shr = prod[SMP_W+MUL_W-1:GAIN_SHIFT];   // arithmetic shift right
assign sum      = prod_shr + cfg_i.offset;

// in range when all bits above the new sign agree with it
assign sum_ok = (&sum[SMP_W+MUL_W-GAIN_SHIFT:SMP_W-1]) |
                ~(|sum[SMP_W+MUL_W-GAIN_SHIFT:SMP_W-1]);

// clamp to max positive or max negative by sign
assign sat = sum_ok ? sum[SMP_W-1:0]
                    : {sum[SMP_W+MUL_W-GAIN_SHIFT], {(SMP_W-1){~sum[SMP_W+MUL_W-GAIN_SHIFT]}}};

////////////////////
// output stage
////////////////////

always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
    dat_o <= '0;
  else
    dat_o <= sat;     // one cycle through the stage
end

endmodule

`default_nettype wire

// File: source/adc_front_end.sv
/* adc front end
   pin register, offset binary to two's complement, loopback select, calibration */
`timescale 1ns/1ps
`default_nettype none

module adc_front_end import rp_pkg::*; (
  input  logic             adc_clk,
  input  logic             top_rst,
  input  logic [SMP_W-1:0] adc_dat_a_i,   // ch0 pins, negative slope
  input  logic [SMP_W-1:0] adc_dat_b_i,   // ch1 pins
  input  logic             digital_loop_i,
  input  sample_pair_t     loop_dat_i,    // calibrated dac samples
  input  lin_cfg_t [1:0]   cfg_i,
  output sample_pair_t     adc_dat_o
);

pin_pair_t    pin_q;
sample_pair_t raw;
sample_pair_t mux;

// io register, kept free of logic
always_ff @(posedge adc_clk)
begin
  pin_q <= '{ch0: adc_dat_a_i, ch1: adc_dat_b_i};
end

assign raw.ch0 = neg_slope(pin_q.ch0);
assign raw.ch1 = neg_slope(pin_q.ch1);

// loop path skips the pin register
assign mux = digital_loop_i ? loop_dat_i : raw;

////////////////////
// calibration
////////////////////

linear_scaler u_scaler_ch0 (
  .adc_clk (adc_clk      ),
  .top_rst (top_rst      ),
  .dat_i   (mux.ch0      ),
  .cfg_i   (cfg_i[0]     ),
  .dat_o   (adc_dat_o.ch0)
);

linear_scaler u_scaler_ch1 (
  .adc_clk (adc_clk      ),
  .top_rst (top_rst      ),
  .dat_i   (mux.ch1      ),
  .cfg_i   (cfg_i[1]     ),
  .dat_o   (adc_dat_o.ch1)
);

endmodule

`default_nettype wire

// File: source/dac_back_end.sv
/* dac back end
   calibrates the static levels and registers negative slope pin codes */
`timescale 1ns/1ps
`default_nettype none

module dac_back_end import rp_pkg::*; (
  input  logic           adc_clk,
  input  logic           top_rst,
  input  sample_pair_t   dac_level_i,
  input  lin_cfg_t [1:0] cfg_i,
  output sample_pair_t   dac_cal_o,     // also feeds the digital loop
  output pin_pair_t      dac_dat_o
);

////////////////////
// calibration
////////////////////

linear_scaler u_scaler_ch0 (
  .adc_clk (adc_clk        ),
  .top_rst (top_rst        ),
  .dat_i   (dac_level_i.ch0),
  .cfg_i   (cfg_i[0]       ),
  .dat_o   (dac_cal_o.ch0  )
);

linear_scaler u_scaler_ch1 (
  .adc_clk (adc_clk        ),
  .top_rst (top_rst        ),
  .dat_i   (dac_level_i.ch1),
  .cfg_i   (cfg_i[1]       ),
  .dat_o   (dac_cal_o.ch1  )
);

////////////////////
// pin codes
////////////////////

// reset value is the code of a zero sample, 14'h1fff
always_ff @(posedge adc_clk, posedge top_rst)
begin
  if (top_rst)
  begin
    dac_dat_o.ch0 <= neg_slope('0);
    dac_dat_o.ch1 <= neg_slope('0);
  end
  else
  begin
    dac_dat_o.ch0 <= neg_slope(dac_cal_o.ch0);   // sign kept, magnitude flipped
    dac_dat_o.ch1 <= neg_slope(dac_cal_o.ch1);
  end
end

endmodule

`default_nettype wire

// File: source/rp_analog_top.sv
/* analog core top
   bus decoder, register blocks, adc and dac datapaths in the adc_clk domain */
`timescale 1ns/1ps
`default_nettype none

module rp_analog_top import rp_pkg::*; (
  input  logic             adc_clk,
  input  logic             top_rst,
  // system bus
  input  sys_req_t         sys_req_i,
  output sys_rsp_t         sys_rsp_o,
  // adc
  input  logic [SMP_W-1:0] adc_dat_a_i,
  input  logic [SMP_W-1:0] adc_dat_b_i,
  output sample_pair_t     adc_dat_o,
  // dac
  output pin_pair_t        dac_dat_o,
  // leds
  output logic [LED_W-1:0] led_o
);

sys_req_t     hk_req, cal_req;
sys_rsp_t     hk_rsp, cal_rsp;
logic         digital_loop;
sample_pair_t dac_level;
sample_pair_t dac_cal;       // calibrated dac, looped back into adc path
calib_cfg_t   calib;

////////////////////
// bus and registers
////////////////////

sys_bus_decoder u_decoder (
  .sys_req_i (sys_req_i), .sys_rsp_o (sys_rsp_o),
  .hk_req_o  (hk_req   ), .hk_rsp_i  (hk_rsp   ),
  .cal_req_o (cal_req  ), .cal_rsp_i (cal_rsp  )
);

housekeeping_regs u_hk (
  .adc_clk        (adc_clk     ), .top_rst     (top_rst  ),
  .req_i          (hk_req      ), .rsp_o       (hk_rsp   ),
  .led_o          (led_o       ),
  .digital_loop_o (digital_loop), .dac_level_o (dac_level)
);

calib_regs u_calib (
  .adc_clk (adc_clk), .top_rst (top_rst),
  .req_i   (cal_req), .rsp_o   (cal_rsp),
  .calib_o (calib  )
);

////////////////////
// datapaths
////////////////////

adc_front_end u_adc (
  .adc_clk        (adc_clk      ), .top_rst     (top_rst    ),
  .adc_dat_a_i    (adc_dat_a_i  ), .adc_dat_b_i (adc_dat_b_i),
  .digital_loop_i (digital_loop ), .loop_dat_i  (dac_cal    ),
  .cfg_i          (calib.adc_cfg), .adc_dat_o   (adc_dat_o  )
);

dac_back_end u_dac (
  .adc_clk     (adc_clk      ), .top_rst   (top_rst  ),
  .dac_level_i (dac_level    ), .cfg_i     (calib.dac_cfg),
  .dac_cal_o   (dac_cal      ), .dac_dat_o (dac_dat_o)
);

endmodule

`default_nettype wire

// File: tests/tb_rp_analog_top.sv
/* analog core testbench
   random bus, adc pin and dac level stimulus checked against a cycle model */
`timescale 1ns/1ps
`default_nettype none

module tb_rp_analog_top import rp_pkg::*; ();

localparam int CLK_HALF      = 10;
localparam int CLK_PERIOD    = 2 * CLK_HALF;
localparam int RESET_CYCLES  = 5;
localparam int ACK_LIMIT     = 16;                    // bus timeout in cycles
localparam int XFER_MAX      = ACK_LIMIT + 3;         // worst case per transfer
localparam logic [31:0] SEED = 32'h5c09_030a;
localparam int N_REGS        = 12;                    // 4 housekeeping + 8 calib
localparam int N_REG_PASSES  = 8;
localparam int N_UNMAPPED    = 48;
localparam int N_ADC_ROUNDS  = 20;
localparam int ADC_RUN       = 16;                    // free running pins per round
localparam int N_DAC_ROUNDS  = 20;
localparam int N_LOOP_ROUNDS = 20;
localparam int SETTLE        = 4;
localparam int N_XFERS = 3 * N_REGS + N_REG_PASSES * 2 * N_REGS + 2 * N_UNMAPPED + 2 +
                         4 * N_ADC_ROUNDS + 6 * N_DAC_ROUNDS + 10 * N_LOOP_ROUNDS;
localparam int N_IDLE  = RESET_CYCLES + 2 + N_ADC_ROUNDS * ADC_RUN +
                         (N_DAC_ROUNDS + N_LOOP_ROUNDS + 1) * SETTLE;
localparam int WATCHDOG_NS = (N_XFERS * XFER_MAX + N_IDLE + 100) * CLK_PERIOD;
localparam int SMP_MAX = 2 ** (SMP_W - 1) - 1;
localparam int SMP_MIN = -(2 ** (SMP_W - 1));
localparam logic [SMP_W-1:0] MAG_MASK = (1 << (SMP_W - 1)) - 1;  // all but the msb
localparam pin_pair_t DAC_RST_PINS = '{ch0: 14'h1FFF, ch1: 14'h1FFF};

logic             adc_clk;
logic             top_rst;
sys_req_t         sys_req_i;
sys_rsp_t         sys_rsp_o;
logic [SMP_W-1:0] adc_dat_a_i;
logic [SMP_W-1:0] adc_dat_b_i;
sample_pair_t     adc_dat_o;
pin_pair_t        dac_dat_o;
logic [LED_W-1:0] led_o;

// shadow registers
logic             loop_m;
logic [LED_W-1:0] led_m;
sample_pair_t     level_m;
lin_cfg_t         adc_cfg_m [2];
lin_cfg_t         dac_cfg_m [2];

// model pipeline
pin_pair_t        pin_m;
sample_pair_t     adc_exp;
sample_pair_t     dac_cal_m;
pin_pair_t        dac_pin_exp;
logic             mon_en;

int err_sample = 0;
int err_pin    = 0;
int err_word   = 0;
int err_led    = 0;
int err_bus    = 0;                                   // timeouts and latency

rp_analog_top u_dut (
  .adc_clk     (adc_clk    ),
  .top_rst     (top_rst    ),
  .sys_req_i   (sys_req_i  ),
  .sys_rsp_o   (sys_rsp_o  ),
  .adc_dat_a_i (adc_dat_a_i),
  .adc_dat_b_i (adc_dat_b_i),
  .adc_dat_o   (adc_dat_o  ),
  .dac_dat_o   (dac_dat_o  ),
  .led_o       (led_o      )
);

initial adc_clk = 1'b0;
always #CLK_HALF adc_clk = ~adc_clk;

////////////////////
// reference rules
////////////////////

// offset binary pins keep the msb and flip the magnitude
function automatic sample_t pin_to_sample(input logic [SMP_W-1:0] p);
  return sample_t'(p ^ MAG_MASK);
endfunction

function automatic logic [SMP_W-1:0] sample_to_pin(input sample_t s);
  return s ^ MAG_MASK;
endfunction

// gain in units of 2^-14 with a floor shift and a clamp
function automatic sample_t scale(input sample_t x, input lin_cfg_t c);
  int p;
  p = (int'(x) * int'(c.gain)) >>> GAIN_SHIFT;
  p = p + int'(c.offset);
  if (p > SMP_MAX)
    p = SMP_MAX;
  else if (p < SMP_MIN)
    p = SMP_MIN;
  return sample_t'(p);
endfunction

// model steps on the same edge as the dut
always @(posedge adc_clk)
begin
  pin_m <= '{ch0: adc_dat_a_i, ch1: adc_dat_b_i};
  if (top_rst)
  begin
    adc_exp     <= '0;
    dac_cal_m   <= '0;
    dac_pin_exp <= DAC_RST_PINS;
  end
  else
  begin
    adc_exp.ch0     <= scale(loop_m ? dac_cal_m.ch0 : pin_to_sample(pin_m.ch0), adc_cfg_m[0]);
    adc_exp.ch1     <= scale(loop_m ? dac_cal_m.ch1 : pin_to_sample(pin_m.ch1), adc_cfg_m[1]);
    dac_cal_m.ch0   <= scale(level_m.ch0, dac_cfg_m[0]);
    dac_cal_m.ch1   <= scale(level_m.ch1, dac_cfg_m[1]);
    dac_pin_exp.ch0 <= sample_to_pin(dac_cal_m.ch0);      // second dac stage
    dac_pin_exp.ch1 <= sample_to_pin(dac_cal_m.ch1);
  end
end

////////////////////
// compare
////////////////////

task automatic check_samples(input string name, input sample_pair_t exp, input sample_pair_t act);
  if (act !== exp)
  begin
    err_sample++;
    $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
  end
endtask

task automatic check_pins(input string name, input pin_pair_t exp, input pin_pair_t act);
  if (act !== exp)
  begin
    err_pin++;
    $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
  end
endtask

task automatic check_word(input string name, input logic [BUS_W-1:0] exp,
                          input logic [BUS_W-1:0] act);
  if (act !== exp)
  begin
    err_word++;
    $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
  end
endtask

task automatic check_led(input string name, input logic [LED_W-1:0] exp,
                         input logic [LED_W-1:0] act);
  if (act !== exp)
  begin
    err_led++;
    $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
  end
endtask

// datapaths checked every cycle half a period after the edge
always @(negedge adc_clk)
begin
  if (mon_en)
  begin
    check_samples("adc_dat_o", adc_exp, adc_dat_o);
    check_pins("dac_dat_o", dac_pin_exp, dac_dat_o);
  end
end

////////////////////
// register map model
////////////////////

function automatic logic [BUS_W-1:0] reg_addr(input int region, input int ofs);
  return (BUS_W'(region) << REGION_LSB) | BUS_W'(ofs);
endfunction

function automatic logic [BUS_W-1:0] reg_by_index(input int i);
  return (i < 4) ? reg_addr(REGION_HK, 4 * i) : reg_addr(REGION_CALIB, 4 * (i - 4));
endfunction

task automatic apply_write(input logic [BUS_W-1:0] addr, input logic [BUS_W-1:0] d);
  int region;
  int ofs;
  int ch;
  region = addr[REGION_LSB +: 3];
  ofs    = addr[REGION_LSB-1:0];
  ch     = (ofs / 4) % 2;                             // odd words are ch1
  if (region == REGION_HK)
  begin
    case (ofs)
      'h0: loop_m      = d[0];
      'h4: led_m       = d[LED_W-1:0];
      'h8: level_m.ch0 = d[SMP_W-1:0];
      'hC: level_m.ch1 = d[SMP_W-1:0];
      default: ;
    endcase
  end
  else if (region == REGION_CALIB)
  begin
    case (ofs)
      'h00, 'h04: adc_cfg_m[ch].gain   = d[MUL_W-1:0];
      'h08, 'h0C: adc_cfg_m[ch].offset = d[SMP_W-1:0];
      'h10, 'h14: dac_cfg_m[ch].gain   = d[MUL_W-1:0];
      'h18, 'h1C: dac_cfg_m[ch].offset = d[SMP_W-1:0];
      default: ;
    endcase
  end
endtask

// fields read zero extended and everything else reads zero
function automatic logic [BUS_W-1:0] expected_read(input logic [BUS_W-1:0] addr);
  logic [BUS_W-1:0] val;
  int region;
  int ofs;
  int ch;
  val    = '0;
  region = addr[REGION_LSB +: 3];
  ofs    = addr[REGION_LSB-1:0];
  ch     = (ofs / 4) % 2;
  if (region == REGION_HK)
  begin
    case (ofs)
      'h0: val[0]           = loop_m;
      'h4: val[LED_W-1:0]   = led_m;
      'h8: val[SMP_W-1:0]   = level_m.ch0;
      'hC: val[SMP_W-1:0]   = level_m.ch1;
      default: ;
    endcase
  end
  else if (region == REGION_CALIB)
  begin
    case (ofs)
      'h00, 'h04: val[MUL_W-1:0] = adc_cfg_m[ch].gain;
      'h08, 'h0C: val[SMP_W-1:0] = adc_cfg_m[ch].offset;
      'h10, 'h14: val[MUL_W-1:0] = dac_cfg_m[ch].gain;
      'h18, 'h1C: val[SMP_W-1:0] = dac_cfg_m[ch].offset;
      default: ;
    endcase
  end
  return val;
endfunction

////////////////////
// bus master
////////////////////

// one strobe cycle then a wait for ack at the falling edge
task automatic bus_transfer(input logic [BUS_W-1:0] addr, input logic [BUS_W-1:0] wdata,
                            input bit write, output logic [BUS_W-1:0] rdata);
  int wait_cycles;
  int exp_wait;
  bit acked;
  exp_wait    = (addr[REGION_LSB +: 3] <= REGION_CALIB) ? 1 : 0;  // mapped blocks register ack
  wait_cycles = 0;
  @(posedge adc_clk);
  sys_req_i <= '{addr: addr, wdata: wdata, wen: write, ren: !write};
  @(negedge adc_clk);
  while (!sys_rsp_o.ack && wait_cycles < ACK_LIMIT)
  begin
    @(posedge adc_clk);
    sys_req_i.wen <= 1'b0;
    sys_req_i.ren <= 1'b0;
    @(negedge adc_clk);
    wait_cycles++;
  end
  acked = sys_rsp_o.ack;
  rdata = sys_rsp_o.rdata;
  if (!acked)
  begin
    err_bus++;
    $display("no ack within %0d cycles for %s at address %h", ACK_LIMIT,
             write ? "write" : "read", addr);
  end
  else
  begin
    if (wait_cycles != exp_wait)
    begin
      err_bus++;
      $display("ack for address %h came after %0d cycles instead of %0d", addr,
               wait_cycles, exp_wait);
    end
    if (write)
    begin
      apply_write(addr, wdata);                       // dut register changed on this ack
      check_led("led_o", led_m, led_o);
    end
  end
  @(posedge adc_clk);
  sys_req_i.wen <= 1'b0;
  sys_req_i.ren <= 1'b0;
endtask

task automatic write_reg(input logic [BUS_W-1:0] addr, input logic [BUS_W-1:0] d);
  logic [BUS_W-1:0] unused;
  bus_transfer(addr, d, 1'b1, unused);
endtask

task automatic read_and_compare(input logic [BUS_W-1:0] addr);
  logic [BUS_W-1:0] rd;
  bus_transfer(addr, '0, 1'b0, rd);
  check_word("sys_rsp_o.rdata", expected_read(addr), rd);
endtask

task automatic readback_all();
  for (int i = 0; i < N_REGS; i++)
    read_and_compare(reg_by_index(i));
endtask

////////////////////
// stimulus
////////////////////

function automatic gain_t rand_gain();
  gain_t g;
  case ($urandom % 4)
    0: g = GAIN_ONE;
    1: g = gain_t'(int'(GAIN_ONE) + int'($urandom % 2048) - 1024);  // near unity
    default: g = gain_t'($urandom);                                  // up to x2 so it saturates
  endcase
  return g;
endfunction

function automatic sample_t rand_offset();
  sample_t o;
  case ($urandom % 4)
    0: o = '0;
    1: o = sample_t'(int'($urandom % 128) - 64);
    default: o = sample_t'($urandom);
  endcase
  return o;
endfunction

// junk above the field checks truncation
task automatic set_cfg(input bit dac);
  int base;
  base = dac ? 'h10 : 'h00;
  for (int ch = 0; ch < 2; ch++)
  begin
    write_reg(reg_addr(REGION_CALIB, base + 4 * ch), {16'($urandom), rand_gain()});
    write_reg(reg_addr(REGION_CALIB, base + 8 + 4 * ch), {18'($urandom), rand_offset()});
  end
endtask

task automatic set_levels();
  write_reg(reg_addr(REGION_HK, 'h8), $urandom);
  write_reg(reg_addr(REGION_HK, 'hC), $urandom);
endtask

task automatic drive_pins();
  forever
  begin
    @(posedge adc_clk);
    adc_dat_a_i <= SMP_W'($urandom);
    adc_dat_b_i <= SMP_W'($urandom);
  end
endtask

initial
begin
  #(WATCHDOG_NS);
  $display("watchdog expired after %0d ns, test did not complete", WATCHDOG_NS);
  $display("RESULT: FAIL");
  $finish;
end

initial
begin : main
  int region;
  int ofs;
  void'($urandom(SEED));
  top_rst     = 1'b1;
  sys_req_i   = '0;
  adc_dat_a_i = '0;
  adc_dat_b_i = '0;
  mon_en      = 1'b0;
  loop_m      = 1'b0;
  led_m       = '0;
  level_m     = '0;
  for (int i = 0; i < 2; i++)
  begin
    adc_cfg_m[i] = '{gain: GAIN_ONE, offset: '0};
    dac_cfg_m[i] = '{gain: GAIN_ONE, offset: '0};
  end
  repeat (RESET_CYCLES) @(posedge adc_clk);
  top_rst <= 1'b0;

  // reset values still held before the first edge out of reset
  @(negedge adc_clk);
  check_pins("dac_dat_o", DAC_RST_PINS, dac_dat_o);
  check_led("led_o", '0, led_o);
  @(posedge adc_clk);
  mon_en <= 1'b1;
  readback_all();
  fork
    drive_pins();
  join_none

  // random register access
  repeat (N_REG_PASSES)
  begin
    for (int i = 0; i < N_REGS; i++)
      write_reg(reg_by_index(i), $urandom);
    readback_all();
  end

  // holes inside the map, unused offsets and unmapped regions
  repeat (N_UNMAPPED)
  begin
    region = $urandom % N_REGIONS;
    case ($urandom % 3)
      0: ofs = 4 * ($urandom % 8) + 1 + ($urandom % 3);    // unaligned below 32
      1:
      begin
        region = REGION_HK;
        ofs    = 'h10 + 4 * ($urandom % 4);               // words after the housekeeping map
      end
      default: ofs = 32 + ($urandom % ((1 << REGION_LSB) - 32));
    endcase
    write_reg(reg_addr(region, ofs), $urandom);
    read_and_compare(reg_addr(region, ofs));
  end
  readback_all();

  // adc path with pins running
  write_reg(reg_addr(REGION_HK, 'h0), 32'h0);
  repeat (N_ADC_ROUNDS)
  begin
    set_cfg(1'b0);
    repeat (ADC_RUN) @(posedge adc_clk);
  end

  // dac path
  repeat (N_DAC_ROUNDS)
  begin
    set_cfg(1'b1);
    set_levels();
    repeat (SETTLE) @(posedge adc_clk);
  end

  // digital loop with the pins ignored
  write_reg(reg_addr(REGION_HK, 'h0), 32'h1);
  repeat (N_LOOP_ROUNDS)
  begin
    set_cfg(1'b0);
    set_cfg(1'b1);
    set_levels();
    repeat (SETTLE) @(posedge adc_clk);
  end
  readback_all();
  repeat (SETTLE) @(posedge adc_clk);

  $display("errors: samples %0d, pins %0d, read data %0d, leds %0d, bus %0d",
           err_sample, err_pin, err_word, err_led, err_bus);
  if (err_sample + err_pin + err_word + err_led + err_bus == 0)
    $display("RESULT: PASS");
  else
    $display("RESULT: FAIL");
  $finish;
end

endmodule

`default_nettype wire

// File: flist.f
source/rp_pkg.sv
source/sys_bus_decoder.sv
source/housekeeping_regs.sv
source/calib_regs.sv
source/linear_scaler.sv
source/adc_front_end.sv
source/dac_back_end.sv
source/rp_analog_top.sv
tests/tb_rp_analog_top.sv
